//--- bench/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// what the memory should hold, built only from the writes this testbench issues
logic [31:0] shadow [MEM_WORDS];

logic [31:0] rng_state = 32'h995b8a09;

// one step of a galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
        n = n ^ 32'h8020_0003;
    end
    return n;
endfunction

// gathers n random bits, the lfsr moves one step for each of them
task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
        rng_state = lfsr_step(rng_state);
        v = {v[30:0], rng_state[0]};
    end
endtask

// byte lanes with a select bit set take the new data
task automatic shadow_write(input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel);
    logic [MEM_AW-1:0] w;
    w = adr[MEM_AW+1:2];
    for (int b = 0; b < 4; b++) begin
        if (sel[b]) begin
            shadow[w][8*b +: 8] = dat[8*b +: 8];
        end
    end
endtask

// a fetch at bit 1 set joins the upper half of its word with the lower half of the next
function automatic logic [31:0] fetch_ref(input logic [31:0] adr);
    logic [MEM_AW-1:0] w;
    logic [MEM_AW-1:0] n;
    w = adr[MEM_AW+1:2];
    n = (w == MEM_AW'(MEM_WORDS - 1)) ? '0 : w + MEM_AW'(1);
    if (!adr[1]) begin
        return shadow[w];
    end
    return {shadow[n][15:0], shadow[w][31:16]};
endfunction

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    if (actual !== expected) begin
        $display("FAILED at time %0t: %s is %h, expected %h", $time, name, actual, expected);
        $display("Checks failed");
        $fatal(1);
    end
endtask

`endif

//--- bench/tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch
    import fetch_pkg::*;
();

    localparam int RESET_CYCLES = 5;
    localparam int DRIVE_DLY    = 1;
    localparam int N_WRRD       = 32;
    localparam int N_ALIGNED    = 16;
    localparam int N_MISALIGNED = 16;
    localparam int N_MIX_I      = 48;
    localparam int N_MIX_D      = 48;
    localparam int TOTAL_TXN    = MEM_WORDS + 2 * N_WRRD + N_ALIGNED + N_MISALIGNED + 2
                                  + N_MIX_I + N_MIX_D;
    localparam int WATCHDOG_CYCLES = TOTAL_TXN * 20 + RESET_CYCLES;

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] ibus_adr;
    logic        ibus_cyc;
    logic [31:0] ibus_rdt;
    logic        ibus_ack;
    logic [31:0] dbus_adr;
    logic [31:0] dbus_dat;
    logic [3:0]  dbus_sel;
    logic        dbus_we;
    logic        dbus_cyc;
    logic [31:0] dbus_rdt;
    logic        dbus_ack;

    // stimulus for the concurrent phase, drawn up front
    logic [31:0] mix_iadr [N_MIX_I];
    logic [31:0] mix_dadr [N_MIX_D];
    logic [31:0] mix_ddat [N_MIX_D];
    logic [3:0]  mix_dsel [N_MIX_D];
    logic        mix_dwe  [N_MIX_D];

    `include "tb_model.svh"

    fetch_subsystem DUT (
        .clk        (clk),
        .rst        (rst),
        .i_ibus_adr (ibus_adr),
        .i_ibus_cyc (ibus_cyc),
        .o_ibus_rdt (ibus_rdt),
        .o_ibus_ack (ibus_ack),
        .i_dbus_adr (dbus_adr),
        .i_dbus_dat (dbus_dat),
        .i_dbus_sel (dbus_sel),
        .i_dbus_we  (dbus_we),
        .i_dbus_cyc (dbus_cyc),
        .o_dbus_rdt (dbus_rdt),
        .o_dbus_ack (dbus_ack)
    );

    always #10 clk = ~clk;

    // returns the number of cycles from raising cyc to the cycle with ack
    task automatic fetch_word(input logic [31:0] adr, output int cycles);
        @(posedge clk);
        #DRIVE_DLY;
        ibus_adr = adr;
        ibus_cyc = 1'b1;
        cycles = 0;
        @(negedge clk);
        while (!ibus_ack) begin
            cycles++;
            @(negedge clk);
        end
        @(posedge clk);
        #DRIVE_DLY;
        ibus_cyc = 1'b0;
    endtask

    task automatic data_access(input logic [31:0] adr, input logic [31:0] dat,
                               input logic [3:0] sel, input logic we);
        @(posedge clk);
        #DRIVE_DLY;
        dbus_adr = adr;
        dbus_dat = dat;
        dbus_sel = sel;
        dbus_we  = we;
        dbus_cyc = 1'b1;
        @(negedge clk);
        while (!dbus_ack) begin
            @(negedge clk);
        end
        if (we) begin
            shadow_write(adr, dat, sel);
        end
        @(posedge clk);
        #DRIVE_DLY;
        dbus_cyc = 1'b0;
        dbus_we  = 1'b0;
    endtask

    // outputs are sampled on the falling edge, half a cycle away from any change
    always @(negedge clk) begin
        if (rst) begin
            check_value("o_ibus_ack", 32'(ibus_ack), 32'd0);
            check_value("o_dbus_ack", 32'(dbus_ack), 32'd0);
        end else begin
            if (ibus_ack) begin
                check_value("o_ibus_rdt", ibus_rdt, fetch_ref(ibus_adr));
            end
            if (dbus_ack && !dbus_we) begin
                check_value("o_dbus_rdt", dbus_rdt, shadow[dbus_adr[MEM_AW+1:2]]);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: a bus transaction never completed within %0d cycles",
                 WATCHDOG_CYCLES);
        $display("Checks failed");
        $fatal(1);
    end

    initial begin
        logic [31:0] v;
        logic [31:0] adr;
        logic [31:0] dat;
        logic [31:0] sel;
        logic [31:0] half;
        int          lat;
        int          mix_lat;

        rst      = 1'b1;
        ibus_adr = '0;
        ibus_cyc = 1'b0;
        dbus_adr = '0;
        dbus_dat = '0;
        dbus_sel = '0;
        dbus_we  = 1'b0;
        dbus_cyc = 1'b0;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_value("o_ibus_ack", 32'(ibus_ack), 32'd0);
            check_value("o_dbus_ack", 32'(dbus_ack), 32'd0);
        end

        // memory contents start undefined, so every word gets a full write first
        for (int i = 0; i < MEM_WORDS; i++) begin
            draw_bits(32, dat);
            data_access(32'(i) * 4, dat, 4'hf, 1'b1);
        end

        for (int i = 0; i < N_WRRD; i++) begin
            draw_bits(MEM_AW, v);
            adr = v * 4;
            draw_bits(32, dat);
            draw_bits(4, sel);
            data_access(adr, dat, sel[3:0], 1'b1);
            data_access(adr, 32'd0, 4'hf, 1'b0);
        end

        for (int i = 0; i < N_ALIGNED; i++) begin
            draw_bits(MEM_AW, v);
            fetch_word(v * 4, lat);
            check_value("o_ibus_ack latency", 32'(lat), 32'd1);
        end

        for (int i = 0; i < N_MISALIGNED; i++) begin
            draw_bits(MEM_AW, v);
            fetch_word(v * 4 + 2, lat);
            check_value("o_ibus_ack latency", 32'(lat), 32'd3);
        end
        // the last word of memory continues at word 0
        fetch_word(32'(MEM_WORDS - 1) * 4 + 2, lat);
        check_value("o_ibus_ack latency", 32'(lat), 32'd3);
        fetch_word(32'hffff_fffe, lat);
        check_value("o_ibus_ack latency", 32'(lat), 32'd3);

        // fetches stay below word 127 and data traffic above it, so neither sees the other
        for (int i = 0; i < N_MIX_I; i++) begin
            draw_bits(7, v);
            draw_bits(1, half);
            mix_iadr[i] = (v % 127) * 4 + half * 2;
        end
        for (int i = 0; i < N_MIX_D; i++) begin
            draw_bits(7, v);
            mix_dadr[i] = (v + 128) * 4;
            draw_bits(32, mix_ddat[i]);
            draw_bits(4, sel);
            mix_dsel[i] = sel[3:0];
            draw_bits(1, v);
            mix_dwe[i] = v[0];
        end

        fork
            begin
                for (int i = 0; i < N_MIX_I; i++) begin
                    fetch_word(mix_iadr[i], mix_lat);
                end
            end
            begin
                for (int j = 0; j < N_MIX_D; j++) begin
                    data_access(mix_dadr[j], mix_ddat[j], mix_dsel[j], mix_dwe[j]);
                end
            end
        join

        repeat (2) @(posedge clk);
        $display("All checks passed");
        $finish;
    end

endmodule

//--- hdl/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter
    import fetch_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    input  logic [31:0]       i_ibus_adr,
    input  logic              i_ibus_cyc,
    output logic [31:0]       o_ibus_rdt,
    output logic              o_ibus_ack,

    input  logic [31:0]       i_dbus_adr,
    input  logic [31:0]       i_dbus_dat,
    input  logic [3:0]        i_dbus_sel,
    input  logic              i_dbus_we,
    input  logic              i_dbus_cyc,
    output logic [31:0]       o_dbus_rdt,
    output logic              o_dbus_ack,

    output logic [MEM_AW-1:0] o_mem_adr,
    output logic [31:0]       o_mem_dat,
    output logic [3:0]        o_mem_sel,
    output logic              o_mem_we,
    output logic              o_mem_cyc,
    input  logic [31:0]       i_mem_rdt,
    input  logic              i_mem_ack
);

    bus_owner_e owner_q;
    bus_owner_e owner;
    logic       last_ibus_q;

    // when idle the grant is decided in the same cycle as the request
    always_comb begin
        if (owner_q != OWNER_NONE) begin
            owner = owner_q;
        end else if (i_ibus_cyc && i_dbus_cyc) begin
            owner = last_ibus_q ? OWNER_DBUS : OWNER_IBUS;
        end else if (i_ibus_cyc) begin
            owner = OWNER_IBUS;
        end else if (i_dbus_cyc) begin
            owner = OWNER_DBUS;
        end else begin
            owner = OWNER_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            owner_q     <= OWNER_NONE;
            last_ibus_q <= 1'b0;
        end else begin
            owner_q <= i_mem_ack ? OWNER_NONE : owner;
            if (owner_q == OWNER_NONE && owner != OWNER_NONE) begin
                last_ibus_q <= (owner == OWNER_IBUS);
            end
        end
    end

    always_comb begin
        o_mem_adr = '0;
        o_mem_dat = '0;
        o_mem_sel = '0;
        o_mem_we  = 1'b0;
        o_mem_cyc = 1'b0;
        case (owner)
            OWNER_IBUS: begin
                // instruction fetches always read the whole word
                o_mem_adr = i_ibus_adr[MEM_AW+1:2];
                o_mem_sel = 4'hf;
                o_mem_cyc = i_ibus_cyc;
            end
            OWNER_DBUS: begin
                o_mem_adr = i_dbus_adr[MEM_AW+1:2];
                o_mem_dat = i_dbus_dat;
                o_mem_sel = i_dbus_sel;
                o_mem_we  = i_dbus_we;
                o_mem_cyc = i_dbus_cyc;
            end
            default: begin
                o_mem_cyc = 1'b0;
            end
        endcase
    end

    assign o_ibus_ack = i_mem_ack && (owner == OWNER_IBUS);
    assign o_dbus_ack = i_mem_ack && (owner == OWNER_DBUS);
    assign o_ibus_rdt = (owner == OWNER_IBUS) ? i_mem_rdt : '0;
    assign o_dbus_rdt = (owner == OWNER_DBUS) ? i_mem_rdt : '0;

    // a granted transfer keeps the same request on the memory port until the memory answers
    assert property (@(posedge clk) disable iff (rst)
        (o_mem_cyc && !i_mem_ack) |=>
        (o_mem_cyc && $stable({o_mem_adr, o_mem_dat, o_mem_sel, o_mem_we})));

    // an ack only ever goes back to a master that is still waiting for it
    assert property (@(posedge clk) disable iff (rst) o_ibus_ack |-> i_ibus_cyc);
    assert property (@(posedge clk) disable iff (rst) o_dbus_ack |-> i_dbus_cyc);

endmodule

//--- hdl/fetch_aligner.sv
`timescale 1ns/1ps

module fetch_aligner
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic [31:0] i_ibus_adr,
    input  logic        i_ibus_cyc,
    output logic [31:0] o_ibus_rdt,
    output logic        o_ibus_ack,

    output logic [31:0] o_mem_adr,
    output logic        o_mem_cyc,
    input  logic [31:0] i_mem_rdt,
    input  logic        i_mem_ack
);

    align_state_e state_q;
    align_state_e state_d;

    // upper halfword of the first word of a misaligned fetch
    logic [15:0] hw_q;

    logic        misaligned;
    logic        ack_en;
    logic        second_sel;
    logic        capture;

    assign misaligned = i_ibus_adr[1];

    always_comb begin
        ack_en     = 1'b0;
        second_sel = 1'b0;
        capture    = 1'b0;
        case (state_q)
            FETCH_ALIGN: begin
                // a misaligned request cannot be acked before the state moves on
                ack_en = !misaligned;
            end
            FETCH_FIRST: begin
                capture = i_mem_ack;
            end
            FETCH_SECOND: begin
                ack_en     = 1'b1;
                second_sel = 1'b1;
            end
            default: begin
                ack_en = 1'b0;
            end
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            FETCH_ALIGN: begin
                if (i_ibus_cyc && misaligned) begin
                    state_d = FETCH_FIRST;
                end
            end
            FETCH_FIRST: begin
                // the first word may be delayed by arbitration, so wait for its ack
                if (i_mem_ack) begin
                    state_d = FETCH_SECOND;
                end
            end
            FETCH_SECOND: begin
                if (i_mem_ack) begin
                    state_d = FETCH_ALIGN;
                end
            end
            default: begin
                state_d = FETCH_ALIGN;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= FETCH_ALIGN;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            hw_q <= i_mem_rdt[31:16];
        end
    end

    assign o_mem_adr = second_sel ? (i_ibus_adr + 32'd4) : i_ibus_adr;
    // the memory request stays up across both halves of a split fetch
    assign o_mem_cyc = i_ibus_cyc || (state_q != FETCH_ALIGN);

    assign o_ibus_ack = i_mem_ack && ack_en;
    assign o_ibus_rdt = second_sel ? {i_mem_rdt[15:0], hw_q} : i_mem_rdt;

    // the core holds its fetch while both halves of a split fetch are in flight
    assert property (@(posedge clk) disable iff (rst)
        (state_q != FETCH_ALIGN) |-> (i_ibus_cyc && $stable(i_ibus_adr)));

endmodule

//--- hdl/fetch_pkg.sv
package fetch_pkg;

    // memory geometry, one entry per 32-bit word
    localparam int MEM_WORDS = 256;
    localparam int MEM_AW    = $clog2(MEM_WORDS);

    // aligner states
    // a misaligned fetch walks through FETCH_FIRST and FETCH_SECOND
    typedef enum logic [1:0] {
        FETCH_ALIGN  = 2'b00,
        FETCH_FIRST  = 2'b01,
        FETCH_SECOND = 2'b10
    } align_state_e;

    // which master currently holds the memory port
    typedef enum logic [1:0] {
        OWNER_NONE = 2'b00,
        OWNER_IBUS = 2'b01,
        OWNER_DBUS = 2'b10
    } bus_owner_e;

endpackage

//--- hdl/fetch_subsystem.sv
`timescale 1ns/1ps

module fetch_subsystem
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic [31:0] i_ibus_adr,
    input  logic        i_ibus_cyc,
    output logic [31:0] o_ibus_rdt,
    output logic        o_ibus_ack,

    input  logic [31:0] i_dbus_adr,
    input  logic [31:0] i_dbus_dat,
    input  logic [3:0]  i_dbus_sel,
    input  logic        i_dbus_we,
    input  logic        i_dbus_cyc,
    output logic [31:0] o_dbus_rdt,
    output logic        o_dbus_ack
);

    // aligner side of the arbiter
    logic [31:0]       mi_adr;
    logic              mi_cyc;
    logic [31:0]       mi_rdt;
    logic              mi_ack;

    // shared memory port
    logic [MEM_AW-1:0] m_adr;
    logic [31:0]       m_dat;
    logic [3:0]        m_sel;
    logic              m_we;
    logic              m_cyc;
    logic [31:0]       m_rdt;
    logic              m_ack;

    fetch_aligner u_aligner (
        .clk        (clk),
        .rst        (rst),
        .i_ibus_adr (i_ibus_adr),
        .i_ibus_cyc (i_ibus_cyc),
        .o_ibus_rdt (o_ibus_rdt),
        .o_ibus_ack (o_ibus_ack),
        .o_mem_adr  (mi_adr),
        .o_mem_cyc  (mi_cyc),
        .i_mem_rdt  (mi_rdt),
        .i_mem_ack  (mi_ack)
    );

    bus_arbiter u_arbiter (
        .clk        (clk),
        .rst        (rst),
        .i_ibus_adr (mi_adr),
        .i_ibus_cyc (mi_cyc),
        .o_ibus_rdt (mi_rdt),
        .o_ibus_ack (mi_ack),
        .i_dbus_adr (i_dbus_adr),
        .i_dbus_dat (i_dbus_dat),
        .i_dbus_sel (i_dbus_sel),
        .i_dbus_we  (i_dbus_we),
        .i_dbus_cyc (i_dbus_cyc),
        .o_dbus_rdt (o_dbus_rdt),
        .o_dbus_ack (o_dbus_ack),
        .o_mem_adr  (m_adr),
        .o_mem_dat  (m_dat),
        .o_mem_sel  (m_sel),
        .o_mem_we   (m_we),
        .o_mem_cyc  (m_cyc),
        .i_mem_rdt  (m_rdt),
        .i_mem_ack  (m_ack)
    );

    word_mem u_mem (
        .clk   (clk),
        .rst   (rst),
        .i_adr (m_adr),
        .i_dat (m_dat),
        .i_sel (m_sel),
        .i_we  (m_we),
        .i_cyc (m_cyc),
        .o_rdt (m_rdt),
        .o_ack (m_ack)
    );

endmodule

//--- hdl/word_mem.sv
`timescale 1ns/1ps

module word_mem
    import fetch_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    input  logic [MEM_AW-1:0] i_adr,
    input  logic [31:0]       i_dat,
    input  logic [3:0]        i_sel,
    input  logic              i_we,
    input  logic              i_cyc,
    output logic [31:0]       o_rdt,
    output logic              o_ack
);

    logic [31:0] mem [MEM_WORDS];

    logic        access;

    // one access per request, the cycle with ack high starts nothing new
    assign access = i_cyc && !o_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            o_ack <= 1'b0;
        end else begin
            o_ack <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (i_we) begin
                for (int b = 0; b < 4; b++) begin
                    if (i_sel[b]) begin
                        mem[i_adr][8*b +: 8] <= i_dat[8*b +: 8];
                    end
                end
            end else begin
                o_rdt <= mem[i_adr];
            end
        end
    end

    // the requester is still there in the cycle that carries its ack
    assert property (@(posedge clk) disable iff (rst) access |=> i_cyc);

endmodule

//--- list.f
+incdir+bench
hdl/fetch_pkg.sv
hdl/fetch_aligner.sv
hdl/bus_arbiter.sv
hdl/word_mem.sv
hdl/fetch_subsystem.sv
bench/tb_fetch.sv

//--- run.sh
#!/bin/sh
# compiles the testbench with Verilator and runs it, the exit status reports pass or fail
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_fetch \
    -f list.f \
    -o sim_fetch

./obj_dir/sim_fetch
